/* rtl/char_layer.sv */
// fixed 8x8 character layer
// map fetch, pattern row fetch and pixel select
// CPU access to the map and pattern memories
`timescale 1ns/1ps

module char_layer
    import video_pkg::*;
(
    input  logic        clk,
    input  raster_t     raster,
    input  cpu_wr_t     cpu,
    output logic [31:0] cpu_rd,
    output layer_pxl_t  pxl
);

    map_entry_t map_cpu;
    map_entry_t map_vid;
    pat_row_t   pat_cpu;
    pat_row_t   pat_vid;
    logic [6:0] map_idx;
    logic [6:0] pat_idx;
    logic [2:0] h_lo1;
    logic [2:0] v_lo1;
    logic [2:0] h_lo2;
    logic [1:0] bank2;
    logic       map_sel_q;

    // 8 tiles across, 4 tiles down
    assign map_idx = {2'b00, raster.v[4:3], raster.h[5:3]};
    assign pat_idx = {map_vid.code, v_lo1};

    tile_vram #(
        .entry_t ( map_entry_t    ),
        .DEPTH   ( CHAR_MAP_DEPTH )
    ) u_map (
        .clk      ( clk                                ),
        .cpu_idx  ( cpu.idx                            ),
        .cpu_we   ( cpu.we & cpu.sel_char_map          ),
        .cpu_din  ( map_entry_t'(cpu.dat[5:0])         ),
        .cpu_dout ( map_cpu                            ),
        .vid_idx  ( map_idx                            ),
        .vid_dout ( map_vid                            )
    );

    tile_vram #(
        .entry_t ( pat_row_t ),
        .DEPTH   ( PAT_DEPTH )
    ) u_pat (
        .clk      ( clk                       ),
        .cpu_idx  ( cpu.idx                   ),
        .cpu_we   ( cpu.we & cpu.sel_char_pat ),
        .cpu_din  ( pat_row_t'(cpu.dat)       ),
        .cpu_dout ( pat_cpu                   ),
        .vid_idx  ( pat_idx                   ),
        .vid_dout ( pat_vid                   )
    );

    always_ff @(posedge clk) begin
        h_lo1     <= raster.h[2:0];
        v_lo1     <= raster.v[2:0];
        h_lo2     <= h_lo1;
        bank2     <= map_vid.bank;
        pxl.bank  <= bank2;
        pxl.color <= pat_vid[3'd7 - h_lo2];
        map_sel_q <= cpu.sel_char_map;
    end

    assign cpu_rd = map_sel_q ? {26'd0, map_cpu} : pat_cpu;

endmodule

/* rtl/color_mix.sv */
// colour mixer
// layer priority and enables, palette lookup
// blanking delayed to line up with the RGB output
`timescale 1ns/1ps

module color_mix
    import video_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  raster_t     raster,
    input  video_ctrl_t ctrl,
    input  layer_pxl_t  char_pxl,
    input  layer_pxl_t  scr_pxl,
    input  cpu_wr_t     cpu,
    output logic [31:0] cpu_rd,
    output logic [3:0]  red,
    output logic [3:0]  green,
    output logic [3:0]  blue,
    output logic        lhbl_dly,
    output logic        lvbl_dly
);

    logic [PIPE_DLY-1:0] hbl_sr;
    logic [PIPE_DLY-1:0] vbl_sr;
    logic [6:0]          pal_idx;
    logic                pxl_on;
    logic                pxl_on_q;
    logic                visible;
    pal_entry_t          pal_cpu;
    pal_entry_t          pal_vid;

    // opaque char pixels win, char colours use the upper palette half
    always_comb begin
        pal_idx = {1'b0, scr_pxl.bank, scr_pxl.color};
        pxl_on  = ctrl.layer_en[0];
        if (ctrl.layer_en[1] && char_pxl.color != 4'd0) begin
            pal_idx = {1'b1, char_pxl.bank, char_pxl.color};
            pxl_on  = 1'b1;
        end
    end

    tile_vram #(
        .entry_t ( pal_entry_t ),
        .DEPTH   ( PAL_DEPTH   )
    ) u_pal (
        .clk      ( clk                          ),
        .cpu_idx  ( cpu.idx                      ),
        .cpu_we   ( cpu.we & cpu.sel_pal         ),
        .cpu_din  ( pal_entry_t'(cpu.dat[11:0])  ),
        .cpu_dout ( pal_cpu                      ),
        .vid_idx  ( pal_idx                      ),
        .vid_dout ( pal_vid                      )
    );

    // blanking of the pixel whose palette entry is being read
    assign visible = hbl_sr[PIPE_DLY-2] & vbl_sr[PIPE_DLY-2];

    always_ff @(posedge clk) begin
        if (reset) begin
            hbl_sr   <= '0;
            vbl_sr   <= '0;
            pxl_on_q <= 1'b0;
            red      <= '0;
            green    <= '0;
            blue     <= '0;
        end else begin
            hbl_sr   <= {hbl_sr[PIPE_DLY-2:0], raster.lhbl};
            vbl_sr   <= {vbl_sr[PIPE_DLY-2:0], raster.lvbl};
            pxl_on_q <= pxl_on;
            if (pxl_on_q && visible) begin
                red   <= pal_vid.red;
                green <= pal_vid.green;
                blue  <= pal_vid.blue;
            end else begin
                red   <= '0;
                green <= '0;
                blue  <= '0;
            end
        end
    end

    assign lhbl_dly = hbl_sr[PIPE_DLY-1];
    assign lvbl_dly = vbl_sr[PIPE_DLY-1];
    assign cpu_rd   = {20'd0, pal_cpu};

endmodule

/* rtl/scroll_layer.sv */
// scrolling 8x8 tile background layer
// 128x64 playfield that wraps in both directions
// map fetch, pattern row fetch and pixel select
// CPU access to the map and pattern memories
`timescale 1ns/1ps

module scroll_layer
    import video_pkg::*;
(
    input  logic        clk,
    input  raster_t     raster,
    input  video_ctrl_t ctrl,
    input  cpu_wr_t     cpu,
    output logic [31:0] cpu_rd,
    output layer_pxl_t  pxl
);

    map_entry_t map_cpu;
    map_entry_t map_vid;
    pat_row_t   pat_cpu;
    pat_row_t   pat_vid;
    logic [6:0] px;
    logic [5:0] py;
    logic [6:0] map_idx;
    logic [6:0] pat_idx;
    logic [2:0] h_lo1;
    logic [2:0] v_lo1;
    logic [2:0] h_lo2;
    logic [1:0] bank2;
    logic       map_sel_q;

    // playfield position, the counter widths give the wrap
    assign px = raster.h + ctrl.hpos;
    assign py = raster.v + ctrl.vpos;

    // map is 16 tiles wide and 8 tall
    assign map_idx = {py[5:3], px[6:3]};
    assign pat_idx = {map_vid.code, v_lo1};

    tile_vram #(
        .entry_t ( map_entry_t   ),
        .DEPTH   ( SCR_MAP_DEPTH )
    ) u_map (
        .clk      ( clk                        ),
        .cpu_idx  ( cpu.idx                    ),
        .cpu_we   ( cpu.we & cpu.sel_scr_map   ),
        .cpu_din  ( map_entry_t'(cpu.dat[5:0]) ),
        .cpu_dout ( map_cpu                    ),
        .vid_idx  ( map_idx                    ),
        .vid_dout ( map_vid                    )
    );

    tile_vram #(
        .entry_t ( pat_row_t ),
        .DEPTH   ( PAT_DEPTH )
    ) u_pat (
        .clk      ( clk                      ),
        .cpu_idx  ( cpu.idx                  ),
        .cpu_we   ( cpu.we & cpu.sel_scr_pat ),
        .cpu_din  ( pat_row_t'(cpu.dat)      ),
        .cpu_dout ( pat_cpu                  ),
        .vid_idx  ( pat_idx                  ),
        .vid_dout ( pat_vid                  )
    );

    always_ff @(posedge clk) begin
        h_lo1     <= px[2:0];
        v_lo1     <= py[2:0];
        h_lo2     <= h_lo1;
        bank2     <= map_vid.bank;
        pxl.bank  <= bank2;
        pxl.color <= pat_vid[3'd7 - h_lo2];
        map_sel_q <= cpu.sel_scr_map;
    end

    assign cpu_rd = map_sel_q ? {26'd0, map_cpu} : pat_cpu;

endmodule

/* rtl/tile_vram.sv */
// dual port synchronous RAM
// CPU read/write port and video read port
// one cycle read latency on both ports
`timescale 1ns/1ps

module tile_vram #(
    parameter type entry_t = logic [31:0],
    parameter int  DEPTH   = 128
) (
    input  logic       clk,
    input  logic [6:0] cpu_idx,
    input  logic       cpu_we,
    input  entry_t     cpu_din,
    output entry_t     cpu_dout,
    input  logic [6:0] vid_idx,
    output entry_t     vid_dout
);

    localparam int AW = $clog2(DEPTH);

    entry_t     mem [DEPTH];
    logic [AW-1:0] cpu_addr;
    logic [AW-1:0] vid_addr;

    // smaller memories only look at the low index bits
    assign cpu_addr = cpu_idx[AW-1:0];
    assign vid_addr = vid_idx[AW-1:0];

    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu_addr] <= cpu_din;
        end
        // read before write on the CPU port
        cpu_dout <= mem[cpu_addr];
    end

    always_ff @(posedge clk) begin
        vid_dout <= mem[vid_addr];
    end

endmodule

/* rtl/video_bus.sv */
// Wishbone classic slave for the video subsystem
// address decode into memory selects
// single cycle ack, control registers, read data mux
`timescale 1ns/1ps

module video_bus
    import video_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  wb_req_t     wb_in,
    output wb_rsp_t     wb_out,
    output cpu_wr_t     cpu,
    input  logic [31:0] char_rd,
    input  logic [31:0] scr_rd,
    input  logic [31:0] pal_rd,
    output video_ctrl_t ctrl
);

    typedef enum logic [2:0] {
        SRC_NONE,
        SRC_CHAR,
        SRC_SCR,
        SRC_PAL,
        SRC_REG
    } rd_src_t;

    logic        ack;
    logic        req;
    logic        start;
    logic        sel_reg;
    rd_src_t     rd_src;
    rd_src_t     next_src;
    logic [31:0] reg_rd;
    logic [31:0] reg_rd_q;

    function automatic logic in_region(input logic [11:0] adr, input logic [11:0] base,
                                       input int depth);
        return (adr >= base) && ((adr - base) < 12'(depth));
    endfunction

    assign req     = wb_in.cyc & wb_in.stb;
    assign start   = req & ~ack;
    assign sel_reg = in_region(wb_in.adr, ADR_REGS, NUM_REGS);

    // master holds the request until ack, so decode straight from it
    always_comb begin
        cpu.idx          = wb_in.adr[6:0];
        cpu.dat          = wb_in.dat;
        cpu.we           = req & wb_in.we & ack;
        cpu.sel_char_map = in_region(wb_in.adr, ADR_CHAR_MAP, CHAR_MAP_DEPTH);
        cpu.sel_scr_map  = in_region(wb_in.adr, ADR_SCR_MAP, SCR_MAP_DEPTH);
        cpu.sel_char_pat = in_region(wb_in.adr, ADR_CHAR_PAT, PAT_DEPTH);
        cpu.sel_scr_pat  = in_region(wb_in.adr, ADR_SCR_PAT, PAT_DEPTH);
        cpu.sel_pal      = in_region(wb_in.adr, ADR_PALETTE, PAL_DEPTH);
    end

    always_comb begin
        if (cpu.sel_char_map || cpu.sel_char_pat) begin
            next_src = SRC_CHAR;
        end else if (cpu.sel_scr_map || cpu.sel_scr_pat) begin
            next_src = SRC_SCR;
        end else if (cpu.sel_pal) begin
            next_src = SRC_PAL;
        end else if (sel_reg) begin
            next_src = SRC_REG;
        end else begin
            next_src = SRC_NONE;
        end
    end

    always_comb begin
        case (wb_in.adr[1:0])
            2'd0:    reg_rd = {25'd0, ctrl.hpos};
            2'd1:    reg_rd = {26'd0, ctrl.vpos};
            default: reg_rd = {30'd0, ctrl.layer_en};
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ack    <= 1'b0;
            rd_src <= SRC_NONE;
            ctrl   <= '0;
        end else begin
            // ack for one cycle, then low for at least one
            ack <= start;
            if (start) begin
                rd_src <= next_src;
            end
            if (req && ack && wb_in.we && sel_reg) begin
                case (wb_in.adr[1:0])
                    2'd0:    ctrl.hpos     <= wb_in.dat[6:0];
                    2'd1:    ctrl.vpos     <= wb_in.dat[5:0];
                    default: ctrl.layer_en <= wb_in.dat[1:0];
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            reg_rd_q <= reg_rd;
        end
    end

    always_comb begin
        wb_out.ack = ack;
        case (rd_src)
            SRC_CHAR: wb_out.dat = char_rd;
            SRC_SCR:  wb_out.dat = scr_rd;
            SRC_PAL:  wb_out.dat = pal_rd;
            SRC_REG:  wb_out.dat = reg_rd_q;
            default:  wb_out.dat = '0;
        endcase
    end

endmodule

/* rtl/video_pkg.sv */
// tile video subsystem definitions
// raster geometry and pipeline depth
// CPU word address map and memory depths
// memory entry, layer pixel, Wishbone and control types
package video_pkg;

    // raster geometry, one pixel per clk
    localparam int H_TOTAL   = 80;
    localparam int H_VISIBLE = 64;
    localparam int V_TOTAL   = 40;
    localparam int V_VISIBLE = 32;
    // raster position to RGB
    localparam int PIPE_DLY  = 5;

    // memory depths in entries
    localparam int CHAR_MAP_DEPTH = 32;
    localparam int SCR_MAP_DEPTH  = 128;
    localparam int PAT_DEPTH      = 128;
    localparam int PAL_DEPTH      = 128;
    localparam int NUM_REGS       = 3;

    // CPU word addresses
    localparam logic [11:0] ADR_CHAR_MAP = 12'h000;
    localparam logic [11:0] ADR_SCR_MAP  = 12'h100;
    localparam logic [11:0] ADR_CHAR_PAT = 12'h200;
    localparam logic [11:0] ADR_SCR_PAT  = 12'h400;
    localparam logic [11:0] ADR_PALETTE  = 12'h600;
    localparam logic [11:0] ADR_REGS     = 12'h700;

    typedef struct packed {
        logic [3:0] code;
        logic [1:0] bank;
    } map_entry_t;

    // leftmost pixel sits in element 7
    typedef logic [7:0][3:0] pat_row_t;

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } pal_entry_t;

    typedef struct packed {
        logic [1:0] bank;
        logic [3:0] color;
    } layer_pxl_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [11:0] adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic [6:0]  idx;
        logic [31:0] dat;
        logic        we;
        logic        sel_char_map;
        logic        sel_scr_map;
        logic        sel_char_pat;
        logic        sel_scr_pat;
        logic        sel_pal;
    } cpu_wr_t;

    // layer_en bit0 scroll, bit1 char
    typedef struct packed {
        logic [6:0] hpos;
        logic [5:0] vpos;
        logic [1:0] layer_en;
    } video_ctrl_t;

    typedef struct packed {
        logic [6:0] h;
        logic [5:0] v;
        logic       lhbl;
        logic       lvbl;
    } raster_t;

endpackage

/* rtl/video_timing.sv */
// raster timing generator
// horizontal and vertical counters
// active high visible flags for both directions
`timescale 1ns/1ps

module video_timing
    import video_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    output raster_t raster
);

    logic [6:0] h_cnt;
    logic [5:0] v_cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == 7'(H_TOTAL - 1)) begin
            h_cnt <= '0;
            // v steps on the line wrap
            if (v_cnt == 6'(V_TOTAL - 1)) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 6'd1;
            end
        end else begin
            h_cnt <= h_cnt + 7'd1;
        end
    end

    always_comb begin
        raster.h    = h_cnt;
        raster.v    = v_cnt;
        raster.lhbl = h_cnt < 7'(H_VISIBLE);
        raster.lvbl = v_cnt < 6'(V_VISIBLE);
    end

endmodule

/* rtl/video_top.sv */
// tile video subsystem top level
// Wishbone slave, raster timing, char and scroll layers, colour mixer
`timescale 1ns/1ps

module video_top
    import video_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  wb_req_t    wb_in,
    output wb_rsp_t    wb_out,
    output logic [3:0] red,
    output logic [3:0] green,
    output logic [3:0] blue,
    output logic       lhbl_dly,
    output logic       lvbl_dly
);

    cpu_wr_t     cpu;
    video_ctrl_t ctrl;
    raster_t     raster;
    layer_pxl_t  char_pxl;
    layer_pxl_t  scr_pxl;
    logic [31:0] char_rd;
    logic [31:0] scr_rd;
    logic [31:0] pal_rd;

    video_bus u_bus (
        .clk     ( clk     ),
        .reset   ( reset   ),
        .wb_in   ( wb_in   ),
        .wb_out  ( wb_out  ),
        .cpu     ( cpu     ),
        .char_rd ( char_rd ),
        .scr_rd  ( scr_rd  ),
        .pal_rd  ( pal_rd  ),
        .ctrl    ( ctrl    )
    );

    video_timing u_timing (
        .clk    ( clk    ),
        .reset  ( reset  ),
        .raster ( raster )
    );

    char_layer u_char (
        .clk    ( clk      ),
        .raster ( raster   ),
        .cpu    ( cpu      ),
        .cpu_rd ( char_rd  ),
        .pxl    ( char_pxl )
    );

    scroll_layer u_scroll (
        .clk    ( clk     ),
        .raster ( raster  ),
        .ctrl   ( ctrl    ),
        .cpu    ( cpu     ),
        .cpu_rd ( scr_rd  ),
        .pxl    ( scr_pxl )
    );

    color_mix u_colmix (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .raster   ( raster   ),
        .ctrl     ( ctrl     ),
        .char_pxl ( char_pxl ),
        .scr_pxl  ( scr_pxl  ),
        .cpu      ( cpu      ),
        .cpu_rd   ( pal_rd   ),
        .red      ( red      ),
        .green    ( green    ),
        .blue     ( blue     ),
        .lhbl_dly ( lhbl_dly ),
        .lvbl_dly ( lvbl_dly )
    );

endmodule

/* tests/video_ref.svh */
// reference model for the tile video testbench
// shadow copies of the video memories and control registers
// LCG step, bus read-back model and expected pixel colour
`ifndef VIDEO_REF_SVH
`define VIDEO_REF_SVH

localparam logic [31:0] LCG_SEED = 32'h8153;

logic [5:0]  sh_char_map [CHAR_MAP_DEPTH];
logic [5:0]  sh_scr_map  [SCR_MAP_DEPTH];
logic [31:0] sh_char_pat [PAT_DEPTH];
logic [31:0] sh_scr_pat  [PAT_DEPTH];
logic [11:0] sh_pal      [PAL_DEPTH];
logic [6:0]  sh_hpos;
logic [5:0]  sh_vpos;
logic [1:0]  sh_layer_en;

function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
endfunction

// 0 char map, 1 scroll map, 2 char patterns, 3 scroll patterns,
// 4 palette, 5 registers, 6 unmapped
function automatic int addr_region(input logic [11:0] adr);
    if (adr < ADR_CHAR_MAP + CHAR_MAP_DEPTH) return 0;
    if (adr >= ADR_SCR_MAP && adr < ADR_SCR_MAP + SCR_MAP_DEPTH) return 1;
    if (adr >= ADR_CHAR_PAT && adr < ADR_CHAR_PAT + PAT_DEPTH) return 2;
    if (adr >= ADR_SCR_PAT && adr < ADR_SCR_PAT + PAT_DEPTH) return 3;
    if (adr >= ADR_PALETTE && adr < ADR_PALETTE + PAL_DEPTH) return 4;
    if (adr >= ADR_REGS && adr < ADR_REGS + NUM_REGS) return 5;
    return 6;
endfunction

function void update_shadow(input logic [11:0] adr, input logic [31:0] dat);
    case (addr_region(adr))
        0: sh_char_map[adr[4:0]] = dat[5:0];
        1: sh_scr_map[adr[6:0]] = dat[5:0];
        2: sh_char_pat[adr[6:0]] = dat;
        3: sh_scr_pat[adr[6:0]] = dat;
        4: sh_pal[adr[6:0]] = dat[11:0];
        5: begin
            if (adr[1:0] == 2'd0) sh_hpos = dat[6:0];
            else if (adr[1:0] == 2'd1) sh_vpos = dat[5:0];
            else sh_layer_en = dat[1:0];
        end
        default: ;
    endcase
endfunction

// what a bus read must return, unmapped words read as zero
function automatic logic [31:0] shadow_value(input logic [11:0] adr);
    case (addr_region(adr))
        0: return {26'd0, sh_char_map[adr[4:0]]};
        1: return {26'd0, sh_scr_map[adr[6:0]]};
        2: return sh_char_pat[adr[6:0]];
        3: return sh_scr_pat[adr[6:0]];
        4: return {20'd0, sh_pal[adr[6:0]]};
        5: begin
            if (adr[1:0] == 2'd0) return {25'd0, sh_hpos};
            if (adr[1:0] == 2'd1) return {26'd0, sh_vpos};
            return {30'd0, sh_layer_en};
        end
        default: return 32'd0;
    endcase
endfunction

// leftmost pixel of a row in the high nibble
function automatic logic [3:0] row_pixel(input logic [31:0] row, input int x);
    return row[(7 - x) * 4 +: 4];
endfunction

// {bank, colour} of the char layer at a screen position
function automatic logic [5:0] char_pixel(input int h, input int v);
    logic [5:0] ent;
    ent = sh_char_map[(v / 8) * 8 + h / 8];
    return {ent[1:0], row_pixel(sh_char_pat[ent[5:2] * 8 + v % 8], h % 8)};
endfunction

// scroll layer, playfield 128 by 64 pixels and 16 tiles wide
function automatic logic [5:0] scroll_pixel(input int h, input int v);
    int px;
    int py;
    logic [5:0] ent;
    px = (h + sh_hpos) % 128;
    py = (v + sh_vpos) % 64;
    ent = sh_scr_map[(py / 8) * 16 + px / 8];
    return {ent[1:0], row_pixel(sh_scr_pat[ent[5:2] * 8 + py % 8], px % 8)};
endfunction

function automatic logic [11:0] expected_rgb(input int h, input int v);
    logic [5:0] cp;
    logic [5:0] sp;
    cp = char_pixel(h, v);
    sp = scroll_pixel(h, v);
    if (sh_layer_en[1] && cp[3:0] != 4'd0) return sh_pal[64 + cp[5:4] * 16 + cp[3:0]];
    if (sh_layer_en[0]) return sh_pal[sp[5:4] * 16 + sp[3:0]];
    return 12'h000;
endfunction

`endif

/* tests/video_tb.sv */
// testbench for the tile video subsystem
// Wishbone access tasks with shadow model update
// frame capture compared against the reference model
// read-back, layer, scroll wrap, priority and blanking tests
`timescale 1ns/1ps

module video_tb
    import video_pkg::*;
();

    localparam int ACK_TIMEOUT   = 16;
    localparam int FRAME_TIMEOUT = 2 * H_TOTAL * V_TOTAL + 100;
    localparam logic [11:0] HOLES [8] = '{12'h020, 12'h0FF, 12'h180, 12'h280,
                                          12'h480, 12'h680, 12'h703, 12'hA55};

    logic        clk;
    logic        reset;
    wb_req_t     wb_in;
    wb_rsp_t     wb_out;
    logic [3:0]  red;
    logic [3:0]  green;
    logic [3:0]  blue;
    logic        lhbl_dly;
    logic        lvbl_dly;
    int          errors;
    int          checks;
    int          clean_tests;
    int          test_num;
    logic [31:0] lcg_state;

    `include "video_ref.svh"

    video_top DUT (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .wb_in    ( wb_in    ),
        .wb_out   ( wb_out   ),
        .red      ( red      ),
        .green    ( green    ),
        .blue     ( blue     ),
        .lhbl_dly ( lhbl_dly ),
        .lvbl_dly ( lvbl_dly )
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic next_random(output logic [31:0] val);
        lcg_state = lcg_next(lcg_state);
        // low LCG bits are weak, swap the halves
        val = {lcg_state[15:0], lcg_state[31:16]};
    endtask

    task automatic wb_access(input logic [11:0] adr, input logic we, input logic [31:0] dat,
                             output logic [31:0] rdat);
        int wait_cnt;
        rdat = '0;
        wait_cnt = 0;
        @(negedge clk);
        wb_in.cyc = 1'b1;
        wb_in.stb = 1'b1;
        wb_in.we  = we;
        wb_in.adr = adr;
        wb_in.dat = dat;
        @(negedge clk);
        while (!wb_out.ack && wait_cnt < ACK_TIMEOUT) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!wb_out.ack) begin
            $display("timeout: no ack for bus access to address 0x%03h", adr);
            errors++;
        end else begin
            rdat = wb_out.dat;
        end
        // request stays up through the acking edge
        @(negedge clk);
        wb_in.cyc = 1'b0;
        wb_in.stb = 1'b0;
        wb_in.we  = 1'b0;
    endtask

    task automatic bus_write(input logic [11:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        wb_access(adr, 1'b1, dat, unused);
        update_shadow(adr, dat);
    endtask

    task automatic check_read(input logic [11:0] adr);
        logic [31:0] got;
        logic [31:0] exp;
        wb_access(adr, 1'b0, 32'd0, got);
        exp = shadow_value(adr);
        checks++;
        if (got !== exp) begin
            $display("ERROR wb_out.dat at 0x%03h: got 0x%08h, expected 0x%08h", adr, got, exp);
            errors++;
        end
    endtask

    task automatic fill_region(input logic [11:0] base, input int depth);
        logic [31:0] r;
        for (int i = 0; i < depth; i++) begin
            next_random(r);
            bus_write(base + 12'(i), r);
        end
    endtask

    task automatic read_region(input logic [11:0] base, input int depth);
        for (int i = 0; i < depth; i++) begin
            check_read(base + 12'(i));
        end
    endtask

    task automatic fill_all_memories();
        fill_region(ADR_CHAR_MAP, CHAR_MAP_DEPTH);
        fill_region(ADR_SCR_MAP, SCR_MAP_DEPTH);
        fill_region(ADR_CHAR_PAT, PAT_DEPTH);
        fill_region(ADR_SCR_PAT, PAT_DEPTH);
        fill_region(ADR_PALETTE, PAL_DEPTH);
    endtask

    // one frame from the first visible pixel, pixels and blanking both checked
    task automatic capture_frame();
        int          n;
        int          x;
        int          y;
        logic        prev;
        logic        found;
        logic [11:0] got;
        logic [11:0] exp;
        n = 0;
        prev = 1'b0;
        found = 1'b0;
        while (!found && n < FRAME_TIMEOUT) begin
            @(negedge clk);
            found = prev && !lvbl_dly;
            prev = lvbl_dly;
            n++;
        end
        if (!found) begin
            $display("timeout: lvbl_dly never fell");
            errors++;
            return;
        end
        found = 1'b0;
        n = 0;
        while (!found && n < FRAME_TIMEOUT) begin
            @(negedge clk);
            found = lvbl_dly;
            n++;
        end
        if (!found) begin
            $display("timeout: lvbl_dly never rose");
            errors++;
            return;
        end
        x = 0;
        y = 0;
        for (int i = 0; i < H_TOTAL * V_TOTAL; i++) begin
            if (i > 0) begin
                @(negedge clk);
            end
            got = {red, green, blue};
            checks++;
            if (lhbl_dly && lvbl_dly) begin
                exp = expected_rgb(x, y);
                if (got !== exp) begin
                    $display("ERROR {red,green,blue} at h=%0d v=%0d: got 0x%03h, expected 0x%03h",
                             x, y, got, exp);
                    errors++;
                end
                x++;
            end else begin
                if (got !== 12'h000) begin
                    $display("ERROR {red,green,blue} in blanking, sample %0d: got 0x%03h, %s",
                             i, got, "expected 0x000");
                    errors++;
                end
                // end of a visible line
                if (x > 0) begin
                    if (x != H_VISIBLE) begin
                        $display("line %0d has %0d visible pixels instead of %0d",
                                 y, x, H_VISIBLE);
                        errors++;
                    end
                    y++;
                    x = 0;
                end
            end
        end
        if (y != V_VISIBLE) begin
            $display("frame has %0d visible lines instead of %0d", y, V_VISIBLE);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int start_err);
        test_num++;
        if (errors == start_err) begin
            $display("test %0d %s: ok", test_num, name);
            clean_tests++;
        end else begin
            $display("test %0d %s: %0d errors", test_num, name, errors - start_err);
        end
    endtask

    initial begin
        int          start_err;
        int          n_clear;
        int          n_solid;
        logic [5:0]  cp;
        logic [31:0] r;
        lcg_state   = LCG_SEED;
        errors      = 0;
        checks      = 0;
        clean_tests = 0;
        test_num    = 0;
        sh_hpos     = '0;
        sh_vpos     = '0;
        sh_layer_en = '0;
        wb_in       = '0;
        reset       = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        start_err = errors;
        fill_all_memories();
        for (int i = 0; i < NUM_REGS; i++) begin
            next_random(r);
            bus_write(ADR_REGS + 12'(i), r);
        end
        read_region(ADR_CHAR_MAP, CHAR_MAP_DEPTH);
        read_region(ADR_SCR_MAP, SCR_MAP_DEPTH);
        read_region(ADR_CHAR_PAT, PAT_DEPTH);
        read_region(ADR_SCR_PAT, PAT_DEPTH);
        read_region(ADR_PALETTE, PAL_DEPTH);
        read_region(ADR_REGS, NUM_REGS);
        for (int i = 0; i < 8; i++) begin
            check_read(HOLES[i]);
        end
        report_test("register and memory read-back", start_err);

        start_err = errors;
        bus_write(ADR_REGS + 12'd2, 32'd2);
        fill_all_memories();
        capture_frame();
        report_test("char layer alone", start_err);

        // offsets large enough that both directions wrap on screen
        start_err = errors;
        next_random(r);
        bus_write(ADR_REGS, 32'd65 + r % 32'd63);
        next_random(r);
        bus_write(ADR_REGS + 12'd1, 32'd33 + r % 32'd31);
        bus_write(ADR_REGS + 12'd2, 32'd1);
        capture_frame();
        report_test("scroll layer with wrap", start_err);

        start_err = errors;
        bus_write(ADR_REGS + 12'd2, 32'd3);
        n_clear = 0;
        n_solid = 0;
        for (int v = 0; v < V_VISIBLE; v++) begin
            for (int h = 0; h < H_VISIBLE; h++) begin
                cp = char_pixel(h, v);
                if (cp[3:0] == 4'd0) n_clear++;
                else n_solid++;
            end
        end
        if (n_clear == 0 || n_solid == 0) begin
            $display("char layer lacks transparent or opaque pixels for the priority test");
            errors++;
        end
        capture_frame();
        report_test("layer priority", start_err);

        start_err = errors;
        capture_frame();
        report_test("blanking and visible area", start_err);

        $display("summary: %0d checks, %0d errors, %0d of %0d tests clean",
                 checks, errors, clean_tests, test_num);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* video_top.f */
+incdir+tests
rtl/video_pkg.sv
rtl/tile_vram.sv
rtl/video_bus.sv
rtl/video_timing.sv
rtl/char_layer.sv
rtl/scroll_layer.sv
rtl/color_mix.sv
rtl/video_top.sv
tests/video_tb.sv
